// File: trace_config.svh
/*
 * tracer build parameters
 * data width, record FIFO depth, consumer credits, cycle stamp width
 */

`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// data and address width of the host pipeline
`define TRACE_XLEN 32

`define TRACE_FIFO_DEPTH 4  // record FIFO entries

// consumer buffer slots, credit count after reset
`define TRACE_CREDITS 2

`define TRACE_CYCLE_W 32  // cycle stamp width

`endif

// File: mips_isa_pkg.sv
/*
 * MIPS subset encodings seen by the tracer
 * opcode, funct and rt selector constants, instruction word union
 */

`default_nettype none

package mips_isa_pkg;

  // primary opcodes
  localparam logic [5:0] op_rtype  = 6'b000000;
  localparam logic [5:0] op_regimm = 6'b000001;  // bgez/bltz, picked by rt
  localparam logic [5:0] op_j      = 6'b000010;
  localparam logic [5:0] op_jal    = 6'b000011;
  localparam logic [5:0] op_beq    = 6'b000100;
  localparam logic [5:0] op_bne    = 6'b000101;
  localparam logic [5:0] op_addiu  = 6'b001001;
  localparam logic [5:0] op_slti   = 6'b001010;
  localparam logic [5:0] op_sltiu  = 6'b001011;
  localparam logic [5:0] op_andi   = 6'b001100;
  localparam logic [5:0] op_ori    = 6'b001101;
  localparam logic [5:0] op_xori   = 6'b001110;
  localparam logic [5:0] op_lui    = 6'b001111;
  localparam logic [5:0] op_lw     = 6'b100011;
  localparam logic [5:0] op_sw     = 6'b101011;

  // funct field of r-type words
  localparam logic [5:0] fn_sll   = 6'b000000;
  localparam logic [5:0] fn_srl   = 6'b000010;
  localparam logic [5:0] fn_sra   = 6'b000011;
  localparam logic [5:0] fn_jr    = 6'b001000;
  localparam logic [5:0] fn_break = 6'b001101;
  localparam logic [5:0] fn_mfhi  = 6'b010000;
  localparam logic [5:0] fn_mflo  = 6'b010010;
  localparam logic [5:0] fn_multu = 6'b011001;
  localparam logic [5:0] fn_addu  = 6'b100001;
  localparam logic [5:0] fn_subu  = 6'b100011;
  localparam logic [5:0] fn_and   = 6'b100100;
  localparam logic [5:0] fn_or    = 6'b100101;
  localparam logic [5:0] fn_xor   = 6'b100110;
  localparam logic [5:0] fn_slt   = 6'b101010;
  localparam logic [5:0] fn_sltu  = 6'b101011;

  localparam logic [4:0] rt_bltz = 5'b00000;
  localparam logic [4:0] rt_bgez = 5'b00001;

  // one word, three field layouts
  typedef union packed {
    struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
    } i;
    struct packed {
      logic [5:0]  op;
      logic [25:0] target26;
    } j;
  } mips_word_u;

endpackage

`default_nettype wire

// File: trace_pkg.sv
/*
 * trace record codes
 * record kinds and instruction classes
 */

`default_nettype none

package trace_pkg;

  localparam int kind_w = 2;
  localparam int cls_w  = 4;

  // what a record describes
  localparam logic [kind_w-1:0] kind_instr   = 2'd0;
  localparam logic [kind_w-1:0] kind_stall   = 2'd1;
  localparam logic [kind_w-1:0] kind_unknown = 2'd2;

  // instruction class, selects the operand layout of a record
  localparam logic [cls_w-1:0] cls_alu_reg = 4'd0;
  localparam logic [cls_w-1:0] cls_shift   = 4'd1;
  localparam logic [cls_w-1:0] cls_alu_imm = 4'd2;
  localparam logic [cls_w-1:0] cls_lui     = 4'd3;
  localparam logic [cls_w-1:0] cls_branch  = 4'd4;
  localparam logic [cls_w-1:0] cls_jump    = 4'd5;
  localparam logic [cls_w-1:0] cls_jr      = 4'd6;
  localparam logic [cls_w-1:0] cls_mult    = 4'd7;
  localparam logic [cls_w-1:0] cls_move    = 4'd8;  // mfhi, mflo
  localparam logic [cls_w-1:0] cls_load    = 4'd9;
  localparam logic [cls_w-1:0] cls_store   = 4'd10;
  localparam logic [cls_w-1:0] cls_break   = 4'd11;
  localparam logic [cls_w-1:0] cls_none    = 4'd15;  // stall or unknown word

endpackage

`default_nettype wire

// File: trace_ifs.sv
/*
 * retire_if   WB slot of the shadow pipeline
 * record_if   decoded trace record toward the sender
 */

`timescale 1ns/1ps
`default_nettype none

`include "trace_config.svh"

interface retire_if;
  logic                   valid;   // one cycle per slot entering WB
  logic                   bubble;  // slot is a stall marker
  logic [`TRACE_XLEN-1:0] addr;
  logic [`TRACE_XLEN-1:0] word;
  logic [`TRACE_XLEN-1:0] alu_a;
  logic [`TRACE_XLEN-1:0] alu_b;
  logic [`TRACE_XLEN-1:0] rs_val;
  logic [`TRACE_XLEN-1:0] rt_val;
  logic [`TRACE_XLEN-1:0] store_val;

  modport source (output valid, bubble, addr, word, alu_a, alu_b, rs_val, rt_val, store_val);
  modport sink (input valid, bubble, addr, word, alu_a, alu_b, rs_val, rt_val, store_val);
endinterface

interface record_if import trace_pkg::*;;
  logic                      push;  // strobe, never back-pressured
  logic [kind_w-1:0]         kind;
  logic [cls_w-1:0]          cls;
  logic [`TRACE_XLEN-1:0]    addr;
  logic [`TRACE_XLEN-1:0]    word;
  logic [`TRACE_XLEN-1:0]    op_a;
  logic [`TRACE_XLEN-1:0]    op_b;
  logic [`TRACE_XLEN-1:0]    result;
  logic [`TRACE_CYCLE_W-1:0] cycle;

  modport source (output push, kind, cls, addr, word, op_a, op_b, result, cycle);
  modport sink (input push, kind, cls, addr, word, op_a, op_b, result, cycle);
endinterface

`default_nettype wire

// File: trace_shadow_pipe.sv
/*
 * shadow copy of the host IF/ID, ID/EX, EX/MEM, MEM/WB registers
 * follows host stalls and marks injected bubbles
 */

`timescale 1ns/1ps
`default_nettype none

`include "trace_config.svh"

module trace_shadow_pipe (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`TRACE_XLEN-1:0] instr_addr,
  input  logic [`TRACE_XLEN-1:0] instr,
  input  logic [`TRACE_XLEN-1:0] rs_data,      // ID stage
  input  logic [`TRACE_XLEN-1:0] rt_data,
  input  logic [`TRACE_XLEN-1:0] alu_in1,      // EX stage
  input  logic [`TRACE_XLEN-1:0] alu_in2,
  input  logic [`TRACE_XLEN-1:0] mem_data_in,  // store data
  input  logic                   hazard_stall,
  input  logic                   break_stall,
  input  logic                   instmiss_stall,
  input  logic                   wb_stall,
  input  logic                   datamiss_stall,
  retire_if.source               retire
);

  logic partial_stall;
  logic full_stall;
  logic front_en;  // IF/ID load
  logic back_en;   // ID/EX onward shift

  logic [`TRACE_XLEN-1:0] ifid_word, ifid_addr;
  logic [`TRACE_XLEN-1:0] idex_word, idex_addr, idex_rs, idex_rt;
  logic [`TRACE_XLEN-1:0] exmem_word, exmem_addr, exmem_rs, exmem_rt;
  logic [`TRACE_XLEN-1:0] exmem_alu_a, exmem_alu_b, exmem_store;
  logic [`TRACE_XLEN-1:0] memwb_word, memwb_addr, memwb_rs, memwb_rt;
  logic [`TRACE_XLEN-1:0] memwb_alu_a, memwb_alu_b, memwb_store;

  logic ifid_valid;
  logic idex_valid, idex_bubble;
  logic exmem_valid, exmem_bubble;
  logic memwb_valid, memwb_bubble;
  logic wb_fresh;  // MEM/WB loaded on the last edge

  assign partial_stall = hazard_stall | break_stall | instmiss_stall;
  assign full_stall    = wb_stall | datamiss_stall;

  // partial stall wins over a full stall
  assign front_en = ~partial_stall & ~full_stall;
  assign back_en  = partial_stall | ~full_stall;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ifid_valid   <= 1'b0;
      idex_valid   <= 1'b0;
      idex_bubble  <= 1'b0;
      exmem_valid  <= 1'b0;
      exmem_bubble <= 1'b0;
      memwb_valid  <= 1'b0;
      memwb_bubble <= 1'b0;
      wb_fresh     <= 1'b0;
    end
    else
    begin
      if (front_en)
        ifid_valid <= 1'b1;
      if (back_en)
      begin
        idex_valid   <= ifid_valid;
        idex_bubble  <= partial_stall;  // held IF/ID leaves a bubble behind
        exmem_valid  <= idex_valid;
        exmem_bubble <= idex_bubble;
        memwb_valid  <= exmem_valid;
        memwb_bubble <= exmem_bubble;
      end
      wb_fresh <= back_en;
    end
  end

  // payload, each operand sampled while its instruction sits in the matching stage
  always_ff @(posedge clk)
  begin
    if (front_en)
    begin
      ifid_word <= instr;
      ifid_addr <= instr_addr;
    end
    if (back_en)
    begin
      idex_word   <= ifid_word;
      idex_addr   <= ifid_addr;
      idex_rs     <= rs_data;
      idex_rt     <= rt_data;
      exmem_word  <= idex_word;
      exmem_addr  <= idex_addr;
      exmem_rs    <= idex_rs;
      exmem_rt    <= idex_rt;
      exmem_alu_a <= alu_in1;
      exmem_alu_b <= alu_in2;
      exmem_store <= mem_data_in;
      memwb_word  <= exmem_word;
      memwb_addr  <= exmem_addr;
      memwb_rs    <= exmem_rs;
      memwb_rt    <= exmem_rt;
      memwb_alu_a <= exmem_alu_a;
      memwb_alu_b <= exmem_alu_b;
      memwb_store <= exmem_store;
    end
  end

  assign retire.valid     = memwb_valid & wb_fresh;
  assign retire.bubble    = memwb_bubble;
  assign retire.addr      = memwb_addr;
  assign retire.word      = memwb_word;
  assign retire.alu_a     = memwb_alu_a;
  assign retire.alu_b     = memwb_alu_b;
  assign retire.rs_val    = memwb_rs;
  assign retire.rt_val    = memwb_rt;
  assign retire.store_val = memwb_store;

endmodule

`default_nettype wire

// File: retire_decoder.sv
/*
 * WB stage decode into a trace record
 * class selection, operand picking, free-running cycle stamp
 */

`timescale 1ns/1ps
`default_nettype none

`include "trace_config.svh"

module retire_decoder import mips_isa_pkg::*, trace_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  retire_if.sink                 retire,
  input  logic [`TRACE_XLEN-1:0] write_data,  // host WB result, same cycle
  record_if.source               rec
);

  localparam int xlen = `TRACE_XLEN;

  mips_word_u              w;
  logic [cls_w-1:0]        cls_sel;
  logic [xlen-1:0]         op_a, op_b, result;
  logic [`TRACE_CYCLE_W-1:0] cycle_cnt;

  assign w = retire.word;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      cycle_cnt <= '0;
    else
      cycle_cnt <= cycle_cnt + 1'b1;
  end

  // class from opcode, funct or rt
  always_comb
  begin
    cls_sel = cls_none;
    case (w.r.op)
      op_rtype:
        case (w.r.funct)
          fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_slt, fn_sltu:
            cls_sel = cls_alu_reg;
          fn_sll, fn_srl, fn_sra: cls_sel = cls_shift;
          fn_jr:                  cls_sel = cls_jr;
          fn_multu:               cls_sel = cls_mult;
          fn_mfhi, fn_mflo:       cls_sel = cls_move;
          fn_break:               cls_sel = cls_break;
          default:                cls_sel = cls_none;
        endcase
      op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori:
        cls_sel = cls_alu_imm;
      op_lui:         cls_sel = cls_lui;
      op_beq, op_bne: cls_sel = cls_branch;
      op_regimm:
        if (w.i.rt == rt_bgez || w.i.rt == rt_bltz)
          cls_sel = cls_branch;
      op_j, op_jal:   cls_sel = cls_jump;
      op_lw:          cls_sel = cls_load;
      op_sw:          cls_sel = cls_store;
      default:        cls_sel = cls_none;
    endcase
  end

  // operand layout per class
  always_comb
  begin
    op_a   = '0;
    op_b   = '0;
    result = '0;
    case (cls_sel)
      cls_alu_reg, cls_alu_imm, cls_load:
      begin
        op_a   = retire.alu_a;
        op_b   = retire.alu_b;
        result = write_data;
      end
      cls_store:
      begin
        op_a   = retire.alu_a;
        op_b   = retire.alu_b;
        result = retire.store_val;
      end
      cls_shift:
      begin
        op_a   = xlen'(w.r.shamt);
        op_b   = retire.alu_b;
        result = write_data;
      end
      cls_lui:
      begin
        op_a   = xlen'(w.i.imm16);
        result = write_data;
      end
      cls_branch:
      begin
        op_a = retire.rs_val;
        if (w.i.op != op_regimm)  // bgez/bltz compare against zero
          op_b = retire.rt_val;
      end
      cls_jump:
      begin
        op_a = xlen'({retire.addr[xlen-1:xlen-4], w.j.target26, 2'b00});
        if (w.j.op == op_jal)
          result = write_data;  // link address into r31
      end
      cls_jr:    op_a = retire.rs_val;
      cls_mult:
      begin
        op_a = retire.alu_a;
        op_b = retire.alu_b;
      end
      cls_move:  result = write_data;
      cls_break: op_a = xlen'({w.r.rs, w.r.rt, w.r.rd, w.r.shamt});  // 20-bit code
      default:   op_a = '0;
    endcase
  end

  always_comb
  begin
    rec.push  = retire.valid;
    rec.cycle = cycle_cnt;
    if (retire.bubble)
    begin
      rec.kind   = kind_stall;
      rec.cls    = cls_none;
      rec.addr   = '0;
      rec.word   = '0;
      rec.op_a   = '0;
      rec.op_b   = '0;
      rec.result = '0;
    end
    else
    begin
      rec.kind   = (cls_sel == cls_none) ? kind_unknown : kind_instr;
      rec.cls    = cls_sel;
      rec.addr   = retire.addr;
      rec.word   = retire.word;
      rec.op_a   = op_a;  // zero for unknown words
      rec.op_b   = op_b;
      rec.result = result;
    end
  end

endmodule

`default_nettype wire

// File: trace_sender.sv
/*
 * record FIFO toward the trace consumer
 * credit counter, one record per credit, sticky overflow flag
 */

`timescale 1ns/1ps
`default_nettype none

`include "trace_config.svh"

module trace_sender import trace_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  record_if.sink                    rec,
  input  logic                      credit_return,  // one pulse per freed slot
  output logic                      trace_valid,
  output logic [kind_w-1:0]         trace_kind,
  output logic [cls_w-1:0]          trace_cls,
  output logic [`TRACE_XLEN-1:0]    trace_addr,
  output logic [`TRACE_XLEN-1:0]    trace_word,
  output logic [`TRACE_XLEN-1:0]    trace_op_a,
  output logic [`TRACE_XLEN-1:0]    trace_op_b,
  output logic [`TRACE_XLEN-1:0]    trace_result,
  output logic [`TRACE_CYCLE_W-1:0] trace_cycle,
  output logic                      trace_overflow
);

  localparam int depth  = `TRACE_FIFO_DEPTH;
  localparam int ptr_w  = (depth > 1) ? $clog2(depth) : 1;
  localparam int rec_w  = kind_w + cls_w + 5 * `TRACE_XLEN + `TRACE_CYCLE_W;
  localparam int cred_w = $clog2(`TRACE_CREDITS + 1);

  logic [rec_w-1:0]  mem [depth];
  logic [rec_w-1:0]  rec_flat;
  logic [ptr_w-1:0]  wr_ptr, rd_ptr;
  logic [ptr_w:0]    count;
  logic [cred_w-1:0] credits;
  logic empty, full, send, accept;

  assign rec_flat = {rec.kind, rec.cls, rec.addr, rec.word,
                     rec.op_a, rec.op_b, rec.result, rec.cycle};

  assign empty  = (count == '0);
  assign full   = (count == (ptr_w + 1)'(depth));
  assign send   = (credits != '0) && !empty;
  assign accept = rec.push && (!full || send);  // a pop frees the slot in time

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      count          <= '0;
      credits        <= cred_w'(`TRACE_CREDITS);
      trace_valid    <= 1'b0;
      trace_overflow <= 1'b0;
    end
    else
    begin
      if (accept)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (send)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (ptr_w + 1)'(accept) - (ptr_w + 1)'(send);

      case ({send, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:
          if (credits != cred_w'(`TRACE_CREDITS))
            credits <= credits + 1'b1;
        default: credits <= credits;  // none, or send and return together
      endcase

      trace_valid <= send;
      if (rec.push && !accept)
        trace_overflow <= 1'b1;  // record lost
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      mem[wr_ptr] <= rec_flat;
    if (send)
      {trace_kind, trace_cls, trace_addr, trace_word,
       trace_op_a, trace_op_b, trace_result, trace_cycle} <= mem[rd_ptr];
  end

endmodule

`default_nettype wire

// File: dmdb_trace_top.sv
/*
 * instruction tracer top level
 * shadow pipeline, WB decoder and credit-based record sender
 */

`timescale 1ns/1ps
`default_nettype none

`include "trace_config.svh"

module dmdb_trace_top import trace_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [`TRACE_XLEN-1:0]    instr_addr,
  input  logic [`TRACE_XLEN-1:0]    instr,
  input  logic [`TRACE_XLEN-1:0]    rs_data,
  input  logic [`TRACE_XLEN-1:0]    rt_data,
  input  logic [`TRACE_XLEN-1:0]    alu_in1,
  input  logic [`TRACE_XLEN-1:0]    alu_in2,
  input  logic [`TRACE_XLEN-1:0]    mem_data_in,
  input  logic [`TRACE_XLEN-1:0]    write_data,
  input  logic                      hazard_stall,
  input  logic                      break_stall,
  input  logic                      instmiss_stall,
  input  logic                      wb_stall,
  input  logic                      datamiss_stall,
  input  logic                      credit_return,
  output logic                      trace_valid,
  output logic [kind_w-1:0]         trace_kind,
  output logic [cls_w-1:0]          trace_cls,
  output logic [`TRACE_XLEN-1:0]    trace_addr,
  output logic [`TRACE_XLEN-1:0]    trace_word,
  output logic [`TRACE_XLEN-1:0]    trace_op_a,
  output logic [`TRACE_XLEN-1:0]    trace_op_b,
  output logic [`TRACE_XLEN-1:0]    trace_result,
  output logic [`TRACE_CYCLE_W-1:0] trace_cycle,
  output logic                      trace_overflow
);

  retire_if retire_bus ();
  record_if rec_bus ();

  trace_shadow_pipe u_pipe (
    .clk, .rst_n, .instr_addr, .instr, .rs_data, .rt_data, .alu_in1, .alu_in2,
    .mem_data_in, .hazard_stall, .break_stall, .instmiss_stall, .wb_stall,
    .datamiss_stall, .retire(retire_bus.source)
  );

  retire_decoder u_decode (
    .clk, .rst_n, .retire(retire_bus.sink), .write_data, .rec(rec_bus.source)
  );

  trace_sender u_send (
    .clk, .rst_n, .rec(rec_bus.sink), .credit_return, .trace_valid, .trace_kind,
    .trace_cls, .trace_addr, .trace_word, .trace_op_a, .trace_op_b, .trace_result,
    .trace_cycle, .trace_overflow
  );

endmodule

`default_nettype wire

// File: tb_dmdb_trace.sv
/*
 * testbench for the instruction tracer top level
 * replays host pipeline cycles from tb_testdata.txt and checks each trace record
 */

`timescale 1ns/1ps
`default_nettype none

`include "trace_config.svh"

module tb_dmdb_trace import trace_pkg::*; ();

  localparam int xlen       = `TRACE_XLEN;
  localparam int cyc_w      = `TRACE_CYCLE_W;
  localparam int clk_period = 100;

  logic              clk;
  logic              rst_n;
  logic [xlen-1:0]   instr_addr, instr, rs_data, rt_data;
  logic [xlen-1:0]   alu_in1, alu_in2, mem_data_in, write_data;
  logic              hazard_stall, break_stall, instmiss_stall, wb_stall, datamiss_stall;
  logic              credit_return;
  logic              trace_valid;
  logic [kind_w-1:0] trace_kind;
  logic [cls_w-1:0]  trace_cls;
  logic [xlen-1:0]   trace_addr, trace_word, trace_op_a, trace_op_b, trace_result;
  logic [cyc_w-1:0]  trace_cycle;
  logic              trace_overflow;

  // one entry per host cycle
  logic [xlen-1:0] s_addr[$], s_instr[$], s_rs[$], s_rt[$];
  logic [xlen-1:0] s_alu1[$], s_alu2[$], s_mem[$], s_wdata[$];
  logic [4:0]      s_stall[$];  // hazard, break, instmiss, wb, datamiss
  logic            s_credit[$];

  // expected records in arrival order
  logic [kind_w-1:0] e_kind[$];
  logic [cls_w-1:0]  e_cls[$];
  logic [xlen-1:0]   e_addr[$], e_word[$], e_op_a[$], e_op_b[$], e_result[$];
  logic              exp_overflow;

  int               exp_idx;
  bit               loaded = 1'b0;
  bit               seen_record;
  logic [cyc_w-1:0] last_cycle;

  dmdb_trace_top u_dut (
    .clk, .rst_n, .instr_addr, .instr, .rs_data, .rt_data, .alu_in1, .alu_in2,
    .mem_data_in, .write_data, .hazard_stall, .break_stall, .instmiss_stall,
    .wb_stall, .datamiss_stall, .credit_return, .trace_valid, .trace_kind,
    .trace_cls, .trace_addr, .trace_word, .trace_op_a, .trace_op_b, .trace_result,
    .trace_cycle, .trace_overflow
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_kind(input logic [kind_w-1:0] got, input logic [kind_w-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("error trace_kind: got 0x%h expected 0x%h (record %0d)",
                               got, exp, exp_idx));
  endtask

  task automatic check_cls(input logic [cls_w-1:0] got, input logic [cls_w-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("error trace_cls: got 0x%h expected 0x%h (record %0d)",
                               got, exp, exp_idx));
  endtask

  task automatic check_word(input string name, input logic [xlen-1:0] got,
                            input logic [xlen-1:0] exp);
    if (got !== exp)
      report_failure($sformatf("error %s: got 0x%h expected 0x%h (record %0d)",
                               name, got, exp, exp_idx));
  endtask

  // stamps must rise from one record to the next
  task automatic check_cycle(input logic [cyc_w-1:0] got);
    if (seen_record && !(got > last_cycle))
      report_failure($sformatf("error trace_cycle: got 0x%h expected above 0x%h",
                               got, last_cycle));
    last_cycle  = got;
    seen_record = 1'b1;
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("error %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic load_testdata();
    int          fd;
    int          n;
    string       line;
    string       tag;
    logic [31:0] v [10];
    fd = $fopen("tb_testdata.txt", "r");
    if (fd == 0)
      report_failure("could not open tb_testdata.txt");
    while ($fgets(line, fd) != 0)
    begin
      n = $sscanf(line, "%s", tag);
      if (n == 1 && tag == "S")
      begin
        n = $sscanf(line, "S %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
        if (n != 10)
          report_failure("a stimulus line in tb_testdata.txt is incomplete");
        s_addr.push_back(v[0]);
        s_instr.push_back(v[1]);
        s_rs.push_back(v[2]);
        s_rt.push_back(v[3]);
        s_alu1.push_back(v[4]);
        s_alu2.push_back(v[5]);
        s_mem.push_back(v[6]);
        s_wdata.push_back(v[7]);
        s_stall.push_back(v[8][4:0]);
        s_credit.push_back(v[9][0]);
      end
      else if (n == 1 && tag == "E")
      begin
        n = $sscanf(line, "E %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
        if (n != 7)
          report_failure("an expected record line in tb_testdata.txt is incomplete");
        e_kind.push_back(v[0][kind_w-1:0]);
        e_cls.push_back(v[1][cls_w-1:0]);
        e_addr.push_back(v[2]);
        e_word.push_back(v[3]);
        e_op_a.push_back(v[4]);
        e_op_b.push_back(v[5]);
        e_result.push_back(v[6]);
      end
      else if (n == 1 && tag == "O")
      begin
        n = $sscanf(line, "O %h", v[0]);
        exp_overflow = v[0][0];
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_line(input int i);
    instr_addr  = s_addr[i];
    instr       = s_instr[i];
    rs_data     = s_rs[i];
    rt_data     = s_rt[i];
    alu_in1     = s_alu1[i];
    alu_in2     = s_alu2[i];
    mem_data_in = s_mem[i];
    write_data  = s_wdata[i];
    {hazard_stall, break_stall, instmiss_stall, wb_stall, datamiss_stall} = s_stall[i];
    credit_return = s_credit[i];
  endtask

  task automatic compare_record();
    if (exp_idx >= e_kind.size())
      report_failure("a trace record arrived after the last expected one");
    check_kind(trace_kind, e_kind[exp_idx]);
    check_cls(trace_cls, e_cls[exp_idx]);
    check_word("trace_addr", trace_addr, e_addr[exp_idx]);
    check_word("trace_word", trace_word, e_word[exp_idx]);
    check_word("trace_op_a", trace_op_a, e_op_a[exp_idx]);
    check_word("trace_op_b", trace_op_b, e_op_b[exp_idx]);
    check_word("trace_result", trace_result, e_result[exp_idx]);
    check_cycle(trace_cycle);
    exp_idx++;
  endtask

  // outputs are registered, stable at the falling edge
  always @(negedge clk)
  begin
    if (rst_n && trace_valid)
      compare_record();
  end

  initial
  begin
    int gap;
    void'($urandom(32'h91cd_b7a5));
    clk            = 1'b0;
    rst_n          = 1'b0;
    instr_addr     = '0;
    instr          = '0;
    rs_data        = '0;
    rt_data        = '0;
    alu_in1        = '0;
    alu_in2        = '0;
    mem_data_in    = '0;
    write_data     = '0;
    hazard_stall   = 1'b0;
    break_stall    = 1'b0;
    instmiss_stall = 1'b0;
    wb_stall       = 1'b0;
    datamiss_stall = 1'b0;
    credit_return  = 1'b0;
    exp_idx        = 0;
    seen_record    = 1'b0;
    last_cycle     = '0;
    exp_overflow   = 1'b0;
    load_testdata();
    loaded = 1'b1;

    repeat (4) @(posedge clk);
    for (int i = 0; i < s_addr.size(); i++)
    begin
      @(negedge clk);
      if (i == 0)
        check_flag("trace_overflow", trace_overflow, 1'b0);  // clear out of reset
      rst_n = 1'b1;
      drive_line(i);
    end

    // host frozen, consumer frees its slots at random gaps
    @(negedge clk);
    {hazard_stall, break_stall, instmiss_stall, datamiss_stall} = 4'b0000;
    wb_stall      = 1'b1;
    credit_return = 1'b0;
    while (exp_idx < e_kind.size())
    begin
      gap = $urandom_range(3, 0);
      repeat (gap) @(negedge clk);
      credit_return = 1'b1;
      @(negedge clk);
      credit_return = 1'b0;
    end
    repeat (4) @(negedge clk);

    check_flag("trace_overflow", trace_overflow, exp_overflow);
    if (exp_idx == e_kind.size())
    begin
      $display("Result: PASSED");
      $finish;
    end
    else
      report_failure("fewer trace records arrived than expected");
  end

  // stimulus length plus margin for the drain
  initial
  begin
    wait (loaded);
    #((s_addr.size() + 50) * clk_period);
    report_failure("watchdog expired before all expected trace records arrived");
  end

endmodule

`default_nettype wire

// File: tb_testdata.txt
# S addr instr rs_data rt_data alu_in1 alu_in2 mem_data_in write_data stall credit_return
#   stall bits 4 hazard, 3 break, 2 instmiss, 1 wb, 0 datamiss
# E kind cls addr word op_a op_b result, then O with the final trace_overflow
S 00400000 00221821 a0000000 b0000000 c0000000 d0000000 e0000000 f0000000 00 1
S 00400004 000220c0 a0000001 b0000001 c0000001 d0000001 e0000001 f0000001 00 1
S 00400008 24250010 a0000002 b0000002 c0000002 d0000002 e0000002 f0000002 00 1
S 0040000c 3c061234 a0000003 b0000003 c0000003 d0000003 e0000003 f0000003 00 1
S 00400010 10220004 a0000004 b0000004 c0000004 d0000004 e0000004 f0000004 00 1
S 00400014 04210002 a0000005 b0000005 c0000005 d0000005 e0000005 f0000005 10 1
S 00400014 04210002 a0000006 b0000006 c0000006 d0000006 e0000006 f0000006 08 1
S 00400014 04210002 a0000007 b0000007 c0000007 d0000007 e0000007 f0000007 00 1
S 00400018 0c100040 a0000008 b0000008 c0000008 d0000008 e0000008 f0000008 04 1
S 00400018 0c100040 a0000009 b0000009 c0000009 d0000009 e0000009 f0000009 00 1
S 0040001c 03e00008 a000000a b000000a c000000a d000000a e000000a f000000a 00 1
S 00400020 00220019 a000000b b000000b c000000b d000000b e000000b f000000b 02 1
S 00400020 00220019 a000000c b000000c c000000c d000000c e000000c f000000c 01 1
S 00400020 00220019 a000000d b000000d c000000d d000000d e000000d f000000d 00 1
S 00400024 00003812 a000000e b000000e c000000e d000000e e000000e f000000e 00 1
S 00400028 8c280004 a000000f b000000f c000000f d000000f e000000f f000000f 00 1
S 0040002c ac280008 a0000010 b0000010 c0000010 d0000010 e0000010 f0000010 00 1
S 00400030 0002af0d a0000011 b0000011 c0000011 d0000011 e0000011 f0000011 00 1
S 00400034 fc000000 a0000012 b0000012 c0000012 d0000012 e0000012 f0000012 00 1
S 00400038 08100000 a0000013 b0000013 c0000013 d0000013 e0000013 f0000013 00 1
# consumer stops returning credits, the xori push finds the FIFO full
S 0040003c 342900ff a0000014 b0000014 c0000014 d0000014 e0000014 f0000014 00 0
S 00400040 38290f0f a0000015 b0000015 c0000015 d0000015 e0000015 f0000015 00 0
S 00400044 00221821 a0000016 b0000016 c0000016 d0000016 e0000016 f0000016 00 0
S 00400048 00221821 a0000017 b0000017 c0000017 d0000017 e0000017 f0000017 00 0
S 0040004c 00221821 a0000018 b0000018 c0000018 d0000018 e0000018 f0000018 00 0
S 00400050 00000000 a0000019 b0000019 c0000019 d0000019 e0000019 f0000019 02 0
E 0 0 00400000 00221821 c0000002 d0000002 f0000004
E 0 1 00400004 000220c0 00000003 d0000003 f0000005
E 0 2 00400008 24250010 c0000004 d0000004 f0000006
E 0 3 0040000c 3c061234 00001234 00000000 f0000007
E 1 f 00000000 00000000 00000000 00000000 00000000
E 1 f 00000000 00000000 00000000 00000000 00000000
E 0 4 00400010 10220004 a0000007 b0000007 00000000
E 1 f 00000000 00000000 00000000 00000000 00000000
E 0 4 00400014 04210002 a0000009 00000000 00000000
E 0 5 00400018 0c100040 00400100 00000000 f000000f
E 0 6 0040001c 03e00008 a000000d 00000000 00000000
E 0 7 00400020 00220019 c000000f d000000f 00000000
E 0 8 00400024 00003812 00000000 00000000 f0000012
E 0 9 00400028 8c280004 c0000011 d0000011 f0000013
E 0 a 0040002c ac280008 c0000012 d0000012 e0000012
E 0 b 00400030 0002af0d 00000abc 00000000 00000000
E 2 f 00400034 fc000000 00000000 00000000 00000000
E 0 5 00400038 08100000 00400000 00000000 00000000
E 0 2 0040003c 342900ff c0000016 d0000016 f0000018
O 1

// File: sim.f
+incdir+.
mips_isa_pkg.sv
trace_pkg.sv
trace_ifs.sv
trace_shadow_pipe.sv
retire_decoder.sv
trace_sender.sv
dmdb_trace_top.sv
tb_dmdb_trace.sv
